//--- design/ex_pkg.sv
`default_nettype none
//------------------------------
// Execute stage package
// Widths, opcode encodings and the structs that carry
// control and data through the EX stage and EX/MEM register
//------------------------------

package ex_pkg;

        localparam int XLEN  = 32;
        localparam int REG_W = 5;

        localparam logic [REG_W-1:0] LINK_REG = 5'd31;

        //------------------------------
        // Opcodes and selects
        //------------------------------
        typedef enum logic [3:0] {
                ALU_ADD  = 4'd0,
                ALU_SUB  = 4'd1,
                ALU_AND  = 4'd2,
                ALU_OR   = 4'd3,
                ALU_XOR  = 4'd4,
                ALU_NOR  = 4'd5,
                ALU_SLT  = 4'd6,
                ALU_SLTU = 4'd7,
                ALU_LUI  = 4'd8
        } alu_op_e;

        typedef enum logic [1:0] {
                SH_SLL = 2'd0,
                SH_SRL = 2'd1,
                SH_SRA = 2'd2
        } shift_op_e;

        typedef enum logic [1:0] {
                RES_ALU   = 2'd0,
                RES_LINK  = 2'd1,
                RES_SHIFT = 2'd2
        } result_sel_e;

        typedef enum logic [1:0] {
                DST_RT   = 2'd0,
                DST_RD   = 2'd1,
                DST_LINK = 2'd2,
                DST_NONE = 2'd3
        } reg_dst_e;

        // Upper bit set means a conditional move
        typedef enum logic [1:0] {
                MOVE_ALWAYS     = 2'd0,
                MOVE_ALWAYS_RSV = 2'd1,
                MOVE_IF_ZERO    = 2'd2,
                MOVE_IF_NZ      = 2'd3
        } move_cond_e;

        typedef enum logic [1:0] {
                FWD_RF  = 2'd0,
                FWD_WB  = 2'd1,
                FWD_MEM = 2'd2
        } fwd_sel_e;

        //------------------------------
        // Control and data bundles
        //------------------------------
        // Controls that only ride through EX
        typedef struct packed {
                logic       memwrite;
                logic       memread;
                logic [2:0] store_op;
                logic [2:0] align_op;
                logic [1:0] wbdata_sel;
        } mem_ctrl_t;

        typedef struct packed {
                logic        alu_src;
                alu_op_e     alu_op;
                move_cond_e  move_cond;
                logic        reg2sn;
                shift_op_e   shift_op;
                result_sel_e result_sel;
                reg_dst_e    reg_dst;
                logic        regwrite;
                mem_ctrl_t   mem;
        } ex_ctrl_t;

        typedef struct packed {
                logic [XLEN-1:0]  pca4;
                logic [REG_W-1:0] rs;
                logic [REG_W-1:0] rt;
                logic [REG_W-1:0] rd;
                logic [REG_W-1:0] sa;
                logic [XLEN-1:0]  a_bus;
                logic [XLEN-1:0]  b_bus;
                logic [XLEN-1:0]  extend_bus;
        } ex_data_t;

        // Pending register write from a later stage
        typedef struct packed {
                logic             regwrite;
                logic [REG_W-1:0] write_num;
                logic [XLEN-1:0]  write_bus;
        } wr_port_t;

        typedef struct packed {
                mem_ctrl_t        mem;
                logic             regwrite;
                logic [REG_W-1:0] write_num;
                logic [XLEN-1:0]  result;
                logic [XLEN-1:0]  b_bus;
        } exm_t;

        typedef struct packed {
                logic [XLEN-1:0] fwd_a;
                logic [XLEN-1:0] fwd_b;
                logic [XLEN-1:0] fun_b;
        } opnd_t;

endpackage

`default_nettype wire

//--- design/ex_forward.sv
`default_nettype none
//------------------------------
// EX operand forwarding
// Picks A and B from MEM, WB or the register file,
// MEM first, then applies the immediate select on B
//------------------------------

module ex_forward (
        input  ex_pkg::ex_data_t ex_data,
        input  logic             alu_src,
        input  ex_pkg::exm_t     m,
        input  ex_pkg::wr_port_t wb,
        output ex_pkg::opnd_t    opnd
);

        ex_pkg::fwd_sel_e sel_a;
        ex_pkg::fwd_sel_e sel_b;

        // Register 0 never matches
        function automatic logic port_hit(
                input logic                     wr_en,
                input logic [ex_pkg::REG_W-1:0] wr_num,
                input logic [ex_pkg::REG_W-1:0] src
        );
                return wr_en && (wr_num != '0) && (wr_num == src);
        endfunction

        function automatic logic [ex_pkg::XLEN-1:0] fwd_mux(
                input ex_pkg::fwd_sel_e        sel,
                input logic [ex_pkg::XLEN-1:0] rf_val
        );
                case (sel)
                        ex_pkg::FWD_MEM: return m.result;
                        ex_pkg::FWD_WB:  return wb.write_bus;
                        default:         return rf_val;
                endcase
        endfunction

        //------------------------------
        // Source compare, MEM over WB
        //------------------------------
        always_comb
        begin
                if (port_hit(m.regwrite, m.write_num, ex_data.rs))
                        sel_a = ex_pkg::FWD_MEM;
                else if (port_hit(wb.regwrite, wb.write_num, ex_data.rs))
                        sel_a = ex_pkg::FWD_WB;
                else
                        sel_a = ex_pkg::FWD_RF;

                if (port_hit(m.regwrite, m.write_num, ex_data.rt))
                        sel_b = ex_pkg::FWD_MEM;
                else if (port_hit(wb.regwrite, wb.write_num, ex_data.rt))
                        sel_b = ex_pkg::FWD_WB;
                else
                        sel_b = ex_pkg::FWD_RF;
        end

        always_comb
        begin
                opnd.fwd_a = fwd_mux(sel_a, ex_data.a_bus);
                opnd.fwd_b = fwd_mux(sel_b, ex_data.b_bus);
                // Immediate replaces B for the ALU and shifter only
                opnd.fun_b = alu_src ? ex_data.extend_bus : opnd.fwd_b;
        end

endmodule

`default_nettype wire

//--- design/ex_alu.sv
`default_nettype none
//------------------------------
// Integer ALU
// Arithmetic, logic, compare and load-upper operations,
// plus the zero test on B for conditional moves
//------------------------------

module ex_alu (
        input  logic [ex_pkg::XLEN-1:0] a,
        input  logic [ex_pkg::XLEN-1:0] b,
        input  ex_pkg::alu_op_e         op,
        input  ex_pkg::move_cond_e      move_cond,
        output logic [ex_pkg::XLEN-1:0] result,
        output logic                    move_ok
);

        logic slt_s;
        logic slt_u;
        logic b_zero;

        assign slt_s  = $signed(a) < $signed(b);
        assign slt_u  = a < b;
        assign b_zero = (b == '0);

        //------------------------------
        // Operation select
        //------------------------------
        always_comb
        begin
                case (op)
                        ex_pkg::ALU_ADD:  result = a + b;
                        ex_pkg::ALU_SUB:  result = a - b;
                        ex_pkg::ALU_AND:  result = a & b;
                        ex_pkg::ALU_OR:   result = a | b;
                        ex_pkg::ALU_XOR:  result = a ^ b;
                        ex_pkg::ALU_NOR:  result = ~(a | b);
                        ex_pkg::ALU_SLT:  result = {{(ex_pkg::XLEN-1){1'b0}}, slt_s};
                        ex_pkg::ALU_SLTU: result = {{(ex_pkg::XLEN-1){1'b0}}, slt_u};
                        // Immediate lands in the upper half
                        ex_pkg::ALU_LUI:  result = b << 16;
                        default:          result = a + b;
                endcase
        end

        // Move check, true for plain writes
        always_comb
        begin
                case (move_cond)
                        ex_pkg::MOVE_IF_ZERO: move_ok = b_zero;
                        ex_pkg::MOVE_IF_NZ:   move_ok = ~b_zero;
                        default:              move_ok = 1'b1;
                endcase
        end

endmodule

`default_nettype wire

//--- design/ex_shifter.sv
`default_nettype none
//------------------------------
// Barrel shifter
// Five levels, logical left/right and arithmetic right
//------------------------------

module ex_shifter (
        input  logic [ex_pkg::XLEN-1:0]  din,
        input  logic [ex_pkg::REG_W-1:0] shamt,
        input  ex_pkg::shift_op_e        op,
        output logic [ex_pkg::XLEN-1:0]  dout
);

        logic                    left;
        logic                    fill;
        logic [ex_pkg::XLEN-1:0] level [0:ex_pkg::REG_W];

        // Left shifts run through the right shifter bit-reversed
        assign left     = (op == ex_pkg::SH_SLL);
        assign fill     = (op == ex_pkg::SH_SRA) & din[ex_pkg::XLEN-1];
        assign level[0] = left ? {<<{din}} : din;

        genvar i;
        generate
                for (i = 0; i < ex_pkg::REG_W; i++)
                begin : g_level
                        localparam int STEP = 1 << i;

                        assign level[i+1] = shamt[i]
                                ? {{STEP{fill}}, level[i][ex_pkg::XLEN-1:STEP]}
                                : level[i];
                end
        endgenerate

        assign dout = left ? {<<{level[ex_pkg::REG_W]}} : level[ex_pkg::REG_W];

endmodule

`default_nettype wire

//--- design/ex_execute.sv
`default_nettype none
//------------------------------
// Execute datapath
// ALU and shifter, result mux with the PC+8 link path,
// destination select and conditional-move write enable
//------------------------------

module ex_execute (
        input  ex_pkg::opnd_t            opnd,
        input  ex_pkg::ex_ctrl_t         ctrl,
        input  ex_pkg::ex_data_t         data,
        output ex_pkg::exm_t             exm_next,
        output logic [ex_pkg::REG_W-1:0] ex_write_num
);

        localparam logic [ex_pkg::XLEN-1:0] PC_STEP = 4;

        logic [ex_pkg::XLEN-1:0]  alu_out;
        logic                     move_ok;
        logic [ex_pkg::REG_W-1:0] shamt;
        logic [ex_pkg::XLEN-1:0]  shift_out;
        logic [ex_pkg::XLEN-1:0]  pca8;
        logic [ex_pkg::XLEN-1:0]  result;

        ex_alu u_alu (
                .a         (opnd.fwd_a),
                .b         (opnd.fun_b),
                .op        (ctrl.alu_op),
                .move_cond (ctrl.move_cond),
                .result    (alu_out),
                .move_ok   (move_ok)
        );

        // Variable shifts take the amount from rs
        assign shamt = ctrl.reg2sn ? opnd.fwd_a[ex_pkg::REG_W-1:0] : data.sa;

        ex_shifter u_shifter (
                .din   (opnd.fun_b),
                .shamt (shamt),
                .op    (ctrl.shift_op),
                .dout  (shift_out)
        );

        //------------------------------
        // Result and destination
        //------------------------------
        assign pca8 = data.pca4 + PC_STEP;

        always_comb
        begin
                case (ctrl.result_sel)
                        ex_pkg::RES_LINK:  result = pca8;
                        ex_pkg::RES_SHIFT: result = shift_out;
                        default:           result = alu_out;
                endcase

                case (ctrl.reg_dst)
                        ex_pkg::DST_RT:   ex_write_num = data.rt;
                        ex_pkg::DST_RD:   ex_write_num = data.rd;
                        ex_pkg::DST_LINK: ex_write_num = ex_pkg::LINK_REG;
                        default:          ex_write_num = '0;
                endcase
        end

        always_comb
        begin
                exm_next.mem       = ctrl.mem;
                // Conditional moves write only when the B test passes
                exm_next.regwrite  = ctrl.move_cond[1] ? move_ok : ctrl.regwrite;
                exm_next.write_num = ex_write_num;
                exm_next.result    = result;
                exm_next.b_bus     = opnd.fwd_b;
        end

endmodule

`default_nettype wire

//--- design/ex_mem_reg.sv
`default_nettype none
//------------------------------
// EX/MEM pipeline register
// Loads every cycle, cleared while in reset
//------------------------------

module ex_mem_reg (
        input  logic         clk,
        input  logic         rst_n,
        input  ex_pkg::exm_t d,
        output ex_pkg::exm_t q
);

        // Clearing all fields keeps write and memory enables off
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        q <= '0;
                end
                else
                begin
                        q <= d;
                end
        end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`default_nettype none
//------------------------------
// Execute stage top
// Forwarding, execute datapath and the EX/MEM register
//------------------------------

module ex_stage (
        input  logic                     clk,
        input  logic                     rst_n,
        input  ex_pkg::ex_ctrl_t         ex_ctrl,
        input  ex_pkg::ex_data_t         ex_data,
        input  ex_pkg::wr_port_t         wb,
        output ex_pkg::exm_t             m,
        output logic [ex_pkg::REG_W-1:0] ex_write_num
);

        ex_pkg::opnd_t opnd;
        ex_pkg::exm_t  exm_next;

        //------------------------------
        // Operands, MEM result feeds back
        //------------------------------
        ex_forward u_forward (
                .ex_data (ex_data),
                .alu_src (ex_ctrl.alu_src),
                .m       (m),
                .wb      (wb),
                .opnd    (opnd)
        );

        ex_execute u_execute (
                .opnd         (opnd),
                .ctrl         (ex_ctrl),
                .data         (ex_data),
                .exm_next     (exm_next),
                .ex_write_num (ex_write_num)
        );

        ex_mem_reg u_ex2m (
                .clk   (clk),
                .rst_n (rst_n),
                .d     (exm_next),
                .q     (m)
        );

endmodule

`default_nettype wire

//--- bench/tb_ex_stage.sv
`default_nettype none
//------------------------------
// EX stage testbench
// Applies vectors from a data file on the falling edge,
// checks ex_write_num at once and m one cycle later
//------------------------------

module tb_ex_stage;

        localparam int PERIOD     = 4;
        localparam int RST_CYCLES = 10;
        // Words per vector line in the data file
        localparam int WORDS      = 18;
        localparam int MEM_DEPTH  = 1024;

        logic                     clk = 1'b0;
        logic                     rst_n;
        ex_pkg::ex_ctrl_t         ex_ctrl;
        ex_pkg::ex_data_t         ex_data;
        ex_pkg::wr_port_t         wb;
        ex_pkg::exm_t             m;
        logic [ex_pkg::REG_W-1:0] ex_write_num;

        logic [31:0] vec [0:MEM_DEPTH-1];
        int          n_vec;
        logic        loaded = 1'b0;
        int          errors = 0;
        int          tests_run = 0;
        int          tests_failed = 0;

        ex_stage uut (
                .clk          (clk),
                .rst_n        (rst_n),
                .ex_ctrl      (ex_ctrl),
                .ex_data      (ex_data),
                .wb           (wb),
                .m            (m),
                .ex_write_num (ex_write_num)
        );

        always #(PERIOD/2) clk = ~clk;

        //------------------------------
        // Helpers
        //------------------------------
        task automatic compare_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at time %0t: %s got %h, expected %h",
                                 $time, name, got, exp);
                end
        endtask

        function automatic ex_pkg::exm_t expected_m(input int base);
                ex_pkg::exm_t e;
                e.mem       = vec[base+12][9:0];
                e.regwrite  = vec[base+13][0];
                e.write_num = vec[base+14][ex_pkg::REG_W-1:0];
                e.result    = vec[base+15];
                e.b_bus     = vec[base+16];
                return e;
        endfunction

        task automatic check_m(input ex_pkg::exm_t exp);
                compare_value("m.mem", {22'd0, m.mem}, {22'd0, exp.mem});
                compare_value("m.regwrite", {31'd0, m.regwrite}, {31'd0, exp.regwrite});
                compare_value("m.write_num", {27'd0, m.write_num}, {27'd0, exp.write_num});
                compare_value("m.result", m.result, exp.result);
                compare_value("m.b_bus", m.b_bus, exp.b_bus);
        endtask

        task automatic apply_vector(input int base);
                ex_ctrl            = vec[base][24:0];
                ex_data.pca4       = vec[base+1];
                ex_data.rs         = vec[base+2][ex_pkg::REG_W-1:0];
                ex_data.rt         = vec[base+3][ex_pkg::REG_W-1:0];
                ex_data.rd         = vec[base+4][ex_pkg::REG_W-1:0];
                ex_data.sa         = vec[base+5][ex_pkg::REG_W-1:0];
                ex_data.a_bus      = vec[base+6];
                ex_data.b_bus      = vec[base+7];
                ex_data.extend_bus = vec[base+8];
                wb.regwrite        = vec[base+9][0];
                wb.write_num       = vec[base+10][ex_pkg::REG_W-1:0];
                wb.write_bus       = vec[base+11];
        endtask

        task automatic end_test(input string name, input int errs_before);
                tests_run++;
                if (errors == errs_before)
                begin
                        $display("Test %s passed", name);
                end
                else
                begin
                        tests_failed++;
                        $display("Test %s failed with %0d mismatches", name,
                                 errors - errs_before);
                end
        endtask

        // m stays cleared in reset even with a live instruction driven
        // Bubble on the inputs for the first cycle after it
        task automatic reset_dut();
                int errs_before;
                errs_before = errors;
                rst_n                = 1'b0;
                ex_ctrl              = '0;
                ex_ctrl.regwrite     = 1'b1;
                ex_ctrl.reg_dst      = ex_pkg::DST_RD;
                ex_ctrl.mem.memwrite = 1'b1;
                ex_ctrl.mem.memread  = 1'b1;
                ex_data              = '0;
                ex_data.rd           = 5'd1;
                ex_data.a_bus        = 32'h0000_0001;
                repeat (RST_CYCLES) @(negedge clk);
                check_m('0);
                rst_n   = 1'b1;
                ex_ctrl = '0;
                ex_data = '0;
                @(negedge clk);
                check_m('0);
                end_test("reset", errs_before);
        endtask

        //------------------------------
        // Load and watchdog
        //------------------------------
        initial
        begin
                $readmemh("bench/ex_input_vectors.txt", vec);
                n_vec  = int'(vec[0]);
                loaded = 1'b1;
                #((n_vec + 20) * PERIOD);
                $display("Timeout: the run did not end within %0d clock cycles", n_vec + 20);
                $display("Finished with errors");
                $finish;
        end

        //------------------------------
        // Main sequence
        //------------------------------
        initial
        begin
                int base;
                int errs_before;
                rst_n   = 1'b0;
                ex_ctrl = '0;
                ex_data = '0;
                wb      = '0;
                wait (loaded);
                reset_dut();
                if (n_vec < 1 || n_vec * WORDS + 1 > MEM_DEPTH)
                begin
                        errors++;
                        $display("The vector count in the data file is missing or out of range");
                end
                else
                begin
                        for (int i = 0; i < n_vec; i++)
                        begin
                                base        = 1 + i * WORDS;
                                errs_before = errors;
                                apply_vector(base);
                                // Destination is combinational
                                #1;
                                compare_value("ex_write_num", {27'd0, ex_write_num},
                                              vec[base+17]);
                                @(negedge clk);
                                check_m(expected_m(base));
                                end_test($sformatf("vector %0d", i), errs_before);
                        end
                end
                $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                         tests_run, tests_failed, errors);
                if (errors == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

endmodule

`default_nettype wire

//--- bench/ex_input_vectors.txt
// EX stage vectors in hex, first value is the vector count
// ctrl pca4 rs rt rd sa a_bus b_bus extend | wb: we num bus
// expected: m.mem m.regwrite m.write_num m.result m.b_bus ex_write_num
19
0000C00 00400000 01 02 03 00 00000010 00000020 00000000 0 00 00000000 000 1 03 00000030 00000020 03
0100C00 00400004 03 04 05 00 11111111 00000010 00000000 1 03 DEADBEEF 000 1 05 00000020 00000010 05
1200400 00400008 06 05 00 00 00000000 00000001 0000FF00 1 06 F0F0F0F0 000 1 05 0000F000 00000020 05
0300C00 0040000C 05 07 08 00 00000000 00000000 00000000 1 07 0000000F 000 1 08 0000F00F 0000000F 08
1400400 00400010 09 0A 00 00 12345678 AAAAAAAA 0000FFFF 0 00 00000000 000 1 0A 1234A987 AAAAAAAA 0A
0500C00 00400014 01 02 0B 00 00FF00FF 0F0F0F0F 00000000 0 00 00000000 000 1 0B F000F000 0F0F0F0F 0B
0600C00 00400018 0B 02 0C 00 00000000 00000001 00000000 0 00 00000000 000 1 0C 00000001 00000001 0C
0700C00 0040001C 03 04 0D 00 F000F000 00000001 00000000 0 00 00000000 000 1 0D 00000000 00000001 0D
1600400 00400020 01 0E 00 00 FFFFFFFE 00000055 FFFFFFFF 0 00 00000000 000 1 0E 00000001 00000055 0E
1800400 00400024 00 0F 00 00 00000000 00000000 00001234 0 00 00000000 000 1 0F 12340000 00000000 0F
0004C00 00400028 00 0F 10 04 00000000 00000000 00000000 0 00 00000000 000 1 10 23400000 12340000 10
000CC00 0040002C 00 11 12 1F 00000000 80000000 00000000 0 00 00000000 000 1 12 00000001 80000000 12
0014C00 00400030 00 13 14 04 00000000 80000000 00000000 0 00 00000000 000 1 14 F8000000 80000000 14
0034C00 00400034 15 16 17 03 00000002 87654321 00000000 1 15 00000008 000 1 17 FF876543 87654321 17
0024C00 00400038 17 18 19 00 00000000 0000000F 00000000 1 17 0000001F 000 1 19 00000078 0000000F 19
002CC00 0040003C 01 02 1A 00 00000024 F0000000 00000000 0 00 00000000 000 1 1A 0F000000 F0000000 1A
1000C00 00400040 01 02 00 00 00000100 00000000 00000023 0 00 00000000 000 1 00 00000123 00000000 00
0301A40 00400044 00 00 00 00 00000000 00000000 00000000 1 00 FFFFFFFF 240 0 00 00000000 00000000 00
1000515 00400048 03 1B 00 00 10000000 00000000 00000008 0 00 00000000 115 1 1B 10000008 00000000 1B
1001A68 0040004C 01 1B 00 00 00002000 00000000 00000010 1 1B 55555555 268 0 00 00002010 10000008 00
0003400 00400050 1F 02 00 00 00000000 00000007 00000000 0 00 00000000 000 1 1F 00400054 00000007 1F
0080800 00400054 1F 03 1C 00 00000000 00000000 00000000 0 00 00000000 000 1 1C 00400054 00000000 1C
0080C00 00400058 01 02 1D 00 00000011 00000001 00000000 0 00 00000000 000 0 1D 00000012 00000001 1D
00C0800 0040005C 01 02 1E 00 00000100 00000000 00000000 1 02 00000005 000 1 1E 00000105 00000005 1E
00C0C00 00400060 04 03 1D 00 00000007 00000000 00000000 0 00 00000000 000 0 1D 00000007 00000000 1D

//--- flist.f
design/ex_pkg.sv
design/ex_forward.sv
design/ex_alu.sv
design/ex_shifter.sv
design/ex_execute.sv
design/ex_mem_reg.sv
design/ex_stage.sv
bench/tb_ex_stage.sv

//--- Makefile
# Verilator build and run for the EX stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source or the list itself changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
